// ==== Makefile ====
# Verilator build and run for the automaton display testbench
TOP := caDisplayTb

.PHONY: all lint clean

all:
	verilator --binary --timing -Wno-fatal -f filelist.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "NO ERRORS"

lint:
	verilator --lint-only --timing -Wall -f filelist.f --top-module caDisplayTop

clean:
	rm -rf obj_dir

// ==== filelist.f ====
+incdir+source
source/caPkg.sv
source/pixelWriteIf.sv
source/vgaScanIf.sv
source/vgaTiming.sv
source/caGenerator.sv
source/frameBuffer.sv
source/videoOut.sv
source/caDisplayTop.sv
sim/caDisplayTb.sv

// ==== sim/caDisplayTb.sv ====
// ------------------------------
// Testbench for the automaton display
// Clock, reset, LFSR, reference rows
// Frame capture and compare tasks
// ------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "caCfg.svh"

module caDisplayTb;
   import caPkg::*;

   localparam int hTotal      = `H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK;
   localparam int vTotal      = `V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK;
   localparam int frameCycles = hTotal * vTotal;

   logic        VGA_CTRL_CLK;
   logic        reset;
   logic        start;
   ruleNumber_t ruleNumber;
   color_t      VGA_R;
   color_t      VGA_G;
   color_t      VGA_B;
   logic        VGA_HS;
   logic        VGA_VS;
   logic        VGA_BLANK;
   logic        done;
   logic [31:0] lfsrState;                    // Random rule source
   ruleNumber_t randomRule;

   caDisplayTop DUT (.*);

   initial begin
      VGA_CTRL_CLK = 1'b0;
      forever #20 VGA_CTRL_CLK = ~VGA_CTRL_CLK; // 40 ns period
   end

   // ------------------------------
   // Reference model and helpers
   // ------------------------------
   function automatic logic [31:0] lfsrStep(logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);  // Galois, taps 32,22,2,1
   endfunction

   // Generation number row, cells outside the row are dead
   function automatic logic [`H_ACTIVE-1:0] refRow(ruleNumber_t rule, int row);
      logic [`H_ACTIVE-1:0] cur;
      logic [`H_ACTIVE-1:0] nxt;
      logic                 l;
      logic                 c;
      logic                 r;
      cur = '0;
      cur[`SEED_COLUMN] = 1'b1;                // Single live cell
      for (int g = 0; g < row; g++) begin
         for (int x = 0; x < `H_ACTIVE; x++) begin
            l = (x > 0) ? cur[x-1] : 1'b0;
            c = cur[x];
            r = (x < `H_ACTIVE - 1) ? cur[x+1] : 1'b0;
            nxt[x] = rule[{l, c, r}];           // Neighbourhood picks the rule bit
         end
         cur = nxt;
      end
      return cur;
   endfunction

   task automatic failRun(string line);
      $display("%s", line);
      $display("ERRORS FOUND");
      $fatal(1, "Simulation stopped at first error");
   endtask

   task automatic checkPixel(string name, color_t expected, color_t actual);
      if (actual !== expected)
         failRun($sformatf("[FAIL] %s: expected %h, actual %h", name, expected, actual));
   endtask

   task automatic checkCount(string name, int expected, int actual);
      if (actual != expected)
         failRun($sformatf("[FAIL] %s: expected %0d, actual %0d", name, expected, actual));
   endtask

   task automatic checkFlag(string name, logic expected, logic actual);
      if (actual !== expected)
         failRun($sformatf("[FAIL] %s: expected %b, actual %b", name, expected, actual));
   endtask

   task automatic takeRule(output ruleNumber_t rule);
      for (int b = 0; b < 8; b++) begin
         lfsrState = lfsrStep(lfsrState);       // One step per bit
         rule[b]   = lfsrState[0];
      end
   endtask

   task automatic pulseStart(ruleNumber_t rule);
      @(negedge VGA_CTRL_CLK);
      ruleNumber = rule;
      start      = 1'b1;
      @(negedge VGA_CTRL_CLK);
      start      = 1'b0;
   endtask

   // Wait for a level on HS (which 0) or VS (which 1)
   task automatic waitSync(logic which, logic level);
      for (int i = 0; i < 2 * frameCycles; i++) begin
         @(negedge VGA_CTRL_CLK);
         if ((which ? VGA_VS : VGA_HS) == level)
            return;
      end
      failRun("Timed out waiting for a sync level");
   endtask

   task automatic waitDone(string name);
      for (int i = 0; i < 40 * frameCycles; i++) begin
         @(negedge VGA_CTRL_CLK);
         if (done)
            return;
      end
      failRun($sformatf("%s: done never rose before the timeout", name));
   endtask

   task automatic checkTiming();
      int   cycles;
      int   width;
      int   lines;
      int   vsWidth;
      logic prevHs;
      logic prevVs;
      waitSync(1'b0, 1'b1);
      waitSync(1'b0, 1'b0);                    // First low cycle of HS
      cycles = 1;
      width  = 1;
      prevHs = 1'b0;
      for (int i = 0; i < 2 * hTotal; i++) begin
         @(negedge VGA_CTRL_CLK);
         if (!VGA_HS && prevHs)
            break;                              // Next falling edge
         cycles++;
         width += !VGA_HS;
         prevHs = VGA_HS;
      end
      checkCount("hsync period", hTotal, cycles);
      checkCount("hsync width", `H_SYNC, width);
      waitSync(1'b1, 1'b1);
      waitSync(1'b1, 1'b0);                    // First low cycle of VS
      lines   = 0;
      vsWidth = 0;
      prevHs  = VGA_HS;
      prevVs  = 1'b0;
      for (int i = 0; i < 2 * frameCycles; i++) begin
         @(negedge VGA_CTRL_CLK);
         if (!VGA_VS && prevVs)
            break;
         if (!VGA_HS && prevHs) begin           // One HS fall per line
            lines++;
            vsWidth += !VGA_VS;
         end
         prevHs = VGA_HS;
         prevVs = VGA_VS;
      end
      checkCount("lines per vsync", vTotal, lines);
      checkCount("vsync width", `V_SYNC, vsWidth);
   endtask

   // ------------------------------
   // Frame capture from HS and VS
   // ------------------------------
   task automatic captureFrame(string name, ruleNumber_t rule, logic withImage, logic expDone);
      int                   hsEdges;
      int                   colCnt;
      int                   visCount;
      int                   cycles;
      int                   row;
      int                   col;
      logic                 prevHs;
      logic                 visible;
      logic [`H_ACTIVE-1:0] rowBits;
      color_t               expColor;
      string                tag;
      waitSync(1'b1, 1'b0);                    // Inside vertical sync
      waitSync(1'b1, 1'b1);                    // Back porch begins
      hsEdges  = 0;
      colCnt   = 0;
      visCount = 0;
      cycles   = 0;
      prevHs   = VGA_HS;
      rowBits  = '0;
      while (hsEdges < vTotal && cycles < 2 * frameCycles) begin  // Whole frame
         @(negedge VGA_CTRL_CLK);
         cycles++;
         if (VGA_HS && !prevHs) begin           // HS ends, H_BACK before column 0
            row = hsEdges - `V_BACK;            // Line that just ended
            checkCount({name, " visible per line"},
                       (row >= 0 && row < `V_ACTIVE) ? `H_ACTIVE : 0, visCount);
            hsEdges++;
            colCnt   = 0;
            visCount = 0;
         end else begin
            colCnt++;
         end
         prevHs  = VGA_HS;
         row     = hsEdges - `V_BACK;
         col     = colCnt - `H_BACK;
         visible = (row >= 0) && (row < `V_ACTIVE) && (col >= 0) && (col < `H_ACTIVE);
         if (VGA_BLANK)
            visCount++;
         if (visible && col == 0)
            rowBits = refRow(rule, row);        // New line of the model
         expColor = (visible && withImage && rowBits[col]) ? '1 : '0;
         tag = $sformatf("%s pixel %0d,%0d", name, col, row);
         checkFlag({tag, " blank"}, visible, VGA_BLANK);
         checkFlag({name, " done"}, expDone, done);
         if (withImage || !visible) begin       // Idle memory is undefined
            checkPixel({tag, " red"}, expColor, VGA_R);
            checkPixel({tag, " green"}, expColor, VGA_G);
            checkPixel({tag, " blue"}, expColor, VGA_B);
         end
      end
      if (hsEdges < vTotal)
         failRun({name, ": horizontal sync stopped during frame capture"});
   endtask

   // ------------------------------
   // Test sequence
   // ------------------------------
   initial begin
      reset      = 1'b1;
      start      = 1'b0;
      ruleNumber = '0;
      lfsrState  = 32'h2d19;
      repeat (8) @(negedge VGA_CTRL_CLK);
      reset = 1'b0;

      checkTiming();
      captureFrame("idle", '0, 1'b0, 1'b0);     // No start yet

      pulseStart(8'd254);
      waitDone("rule 254");
      captureFrame("rule 254", 8'd254, 1'b1, 1'b1);

      repeat (3) begin                          // Clear must remove the old image
         takeRule(randomRule);
         pulseStart(randomRule);
         waitDone("random rule");
         captureFrame($sformatf("rule %0d", randomRule), randomRule, 1'b1, 1'b1);
      end

      // Second start lands in the clear phase
      pulseStart(8'd90);
      repeat (200) @(negedge VGA_CTRL_CLK);
      pulseStart(8'd30);
      checkFlag("busy start done", 1'b0, done);
      waitDone("busy start");
      captureFrame("busy start", 8'd90, 1'b1, 1'b1);

      pulseStart(8'd110);
      repeat (20000) @(negedge VGA_CTRL_CLK);   // Well inside the run
      reset = 1'b1;
      repeat (8) @(negedge VGA_CTRL_CLK);
      reset = 1'b0;
      checkFlag("reset mid-run done", 1'b0, done);
      pulseStart(8'd150);
      waitDone("after reset");
      captureFrame("after reset", 8'd150, 1'b1, 1'b1);

      $display("NO ERRORS");
      $finish;
   end

endmodule

`default_nettype wire

// ==== source/caCfg.svh ====
// ----------------------------
// Screen geometry and VGA timing macros
// Small 64x48 mode by default, 640x480 values in the comments
// ----------------------------
`ifndef CA_CFG_SVH
`define CA_CFG_SVH

// Horizontal timing in clock cycles
`define H_ACTIVE 64                  // 640 for full VGA
`define H_FRONT  4                   // 16
`define H_SYNC   8                   // 96
`define H_BACK   4                   // 48

// Vertical timing in lines
`define V_ACTIVE 48                  // 480 for full VGA
`define V_FRONT  2                   // 10
`define V_SYNC   2                   // 2
`define V_BACK   2                   // 33

// Seed cell of generation 0
`define SEED_COLUMN (`H_ACTIVE / 2)  // Horizontal centre

`endif

// ==== source/caDisplayTop.sv ====
// ----------------------------
// Cellular automaton VGA display top
// Timing, generator, frame memory, video output
// ----------------------------
`timescale 1ns/1ps
`default_nettype none

module caDisplayTop (
   input  logic               VGA_CTRL_CLK,
   input  logic               reset,
   input  logic               start,
   input  caPkg::ruleNumber_t ruleNumber,
   output caPkg::color_t      VGA_R,
   output caPkg::color_t      VGA_G,
   output caPkg::color_t      VGA_B,
   output logic               VGA_HS,
   output logic               VGA_VS,
   output logic               VGA_BLANK,
   output logic               done
);
   vgaScanIf    scanBus ();           // Timing to memory and output
   pixelWriteIf pixBus ();            // Generator to memory

   logic pixelBit;                    // Memory read data

   vgaTiming timing (
      .VGA_CTRL_CLK (VGA_CTRL_CLK),
      .reset        (reset),
      .scan         (scanBus)
   );

   caGenerator generator (
      .VGA_CTRL_CLK (VGA_CTRL_CLK),
      .reset        (reset),
      .start        (start),
      .ruleNumber   (ruleNumber),
      .done         (done),
      .pix          (pixBus)
   );

   frameBuffer frame (
      .VGA_CTRL_CLK (VGA_CTRL_CLK),
      .scan         (scanBus),
      .pix          (pixBus),
      .pixelBit     (pixelBit)
   );

   videoOut video (
      .VGA_CTRL_CLK (VGA_CTRL_CLK),
      .reset        (reset),
      .scan         (scanBus),
      .pixelBit     (pixelBit),
      .VGA_R        (VGA_R),
      .VGA_G        (VGA_G),
      .VGA_B        (VGA_B),
      .VGA_HS       (VGA_HS),
      .VGA_VS       (VGA_VS),
      .VGA_BLANK    (VGA_BLANK)
   );

endmodule

`default_nettype wire

// ==== source/caGenerator.sv ====
// ----------------------------
// Automaton generator FSM
// Rule sampling, screen clear, row evolution
// Pixel writes over valid/ready
// ----------------------------
`timescale 1ns/1ps
`default_nettype none
`include "caCfg.svh"

module caGenerator (
   input  logic               VGA_CTRL_CLK,
   input  logic               reset,
   input  logic               start,
   input  caPkg::ruleNumber_t ruleNumber,
   output logic               done,
   pixelWriteIf.writer        pix
);
   import caPkg::*;

   localparam int colBits = $clog2(`H_ACTIVE);
   localparam logic [`H_ACTIVE-1:0] seedRow =
      {{(`H_ACTIVE-1){1'b0}}, 1'b1} << `SEED_COLUMN;

   genState_t            state;
   ruleNumber_t          heldRule;      // Sampled at start
   logic [`H_ACTIVE-1:0] currentGen;    // Row being written
   logic [`H_ACTIVE-1:0] evolvedRow;
   logic [`H_ACTIVE-1:0] nextRow;
   logic [`H_ACTIVE+1:0] paddedGen;     // Dead cell on each side
   yCoord_t              rowCount;
   xCoord_t              nextX;
   logic                 accepted;
   logic                 lastCol;

   assign accepted  = pix.valid && pix.ready;
   assign lastCol   = (pix.x == xCoord_t'(`H_ACTIVE - 1));
   assign nextX     = pix.x + 1'b1;
   assign paddedGen = {1'b0, currentGen, 1'b0};

   // ----------------------------
   // Whole next row in one cycle
   // ----------------------------
   always_comb begin
      for (int i = 0; i < `H_ACTIVE; i++) begin
         // Left is column i-1, which lands in paddedGen[i]
         evolvedRow[i] = heldRule[{paddedGen[i], paddedGen[i+1], paddedGen[i+2]}];
      end
   end

   assign nextRow = (rowCount == '0) ? seedRow : evolvedRow;  // Row 0 is the seed

   // ----------------------------
   // Sequencer
   // ----------------------------
   always_ff @(posedge VGA_CTRL_CLK) begin
      if (reset) begin
         state     <= genIdle;
         done      <= 1'b0;
         pix.valid <= 1'b0;
         rowCount  <= '0;
      end else begin
         case (state)
            genIdle: begin
               if (start) begin
                  heldRule  <= ruleNumber;
                  done      <= 1'b0;
                  pix.x     <= '0;
                  pix.y     <= '0;
                  pix.value <= 1'b0;               // Clear writes black
                  pix.valid <= 1'b1;
                  state     <= genClear;
               end
            end
            genClear: begin
               if (accepted) begin
                  if (!lastCol) begin
                     pix.x <= nextX;
                  end else if (pix.y != yCoord_t'(`V_ACTIVE - 1)) begin
                     pix.x <= '0;
                     pix.y <= pix.y + 1'b1;
                  end else begin
                     pix.valid <= 1'b0;            // Screen is black
                     rowCount  <= '0;
                     state     <= genEvolve;
                  end
               end
            end
            genEvolve: begin
               currentGen <= nextRow;
               pix.x      <= '0;
               pix.y      <= rowCount;
               pix.value  <= nextRow[0];           // First cell of new row
               pix.valid  <= 1'b1;
               state      <= genWrite;
            end
            genWrite: begin
               if (accepted) begin
                  if (!lastCol) begin
                     pix.x     <= nextX;
                     pix.value <= currentGen[nextX[colBits-1:0]];
                  end else begin
                     pix.valid <= 1'b0;
                     if (rowCount == yCoord_t'(`V_ACTIVE - 1)) begin
                        done  <= 1'b1;             // Last row landed
                        state <= genIdle;
                     end else begin
                        rowCount <= rowCount + 1'b1;
                        state    <= genEvolve;
                     end
                  end
               end
            end
            default: state <= genIdle;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== source/caPkg.sv ====
// ----------------------------
// Shared types for the cellular automaton display
// Coordinates, rule, generator state, colour
// ----------------------------
`default_nettype none

package caPkg;

   typedef logic [9:0] xCoord_t;      // Column, up to 800 clocks per line
   typedef logic [8:0] yCoord_t;      // Row inside the visible area

   // Bit k is the new cell for neighbourhood {left, centre, right} == k
   typedef logic [7:0] ruleNumber_t;

   typedef enum logic [1:0] {
      genIdle   = 2'd0,               // Waiting for start
      genClear  = 2'd1,               // Zeroing the frame memory
      genEvolve = 2'd2,               // Computing the next row
      genWrite  = 2'd3                // Writing the row out
   } genState_t;

   typedef logic [9:0] color_t;       // One DAC channel

endpackage

`default_nettype wire

// ==== source/frameBuffer.sv ====
// ----------------------------
// One bit per pixel frame memory
// Write port gated by vertical blank
// Registered read port on scan
// ----------------------------
`timescale 1ns/1ps
`default_nettype none
`include "caCfg.svh"

module frameBuffer (
   input  logic       VGA_CTRL_CLK,
   vgaScanIf.sink     scan,
   pixelWriteIf.store pix,
   output logic       pixelBit
);
   localparam int xBits = $clog2(`H_ACTIVE);
   localparam int yBits = $clog2(`V_ACTIVE);
   localparam int depth = 1 << (xBits + yBits);

   logic                   pixelMem [0:depth-1];   // Address is {x, y}
   logic [xBits+yBits-1:0] writeAddr;
   logic [xBits+yBits-1:0] readAddr;

   // Updates only between frames, no tearing
   assign pix.ready = scan.vBlank;

   assign writeAddr = {pix.x[xBits-1:0], pix.y[yBits-1:0]};
   assign readAddr  = {scan.x[xBits-1:0], scan.y[yBits-1:0]};  // Wraps in blanking

   // Write side
   always_ff @(posedge VGA_CTRL_CLK) begin
      if (pix.valid && pix.ready)
         pixelMem[writeAddr] <= pix.value;
   end

   // Read side, one cycle behind scan
   always_ff @(posedge VGA_CTRL_CLK) begin
      pixelBit <= pixelMem[readAddr];
   end

endmodule

`default_nettype wire

// ==== source/pixelWriteIf.sv ====
// ----------------------------
// Single pixel write with valid/ready
// ----------------------------
`timescale 1ns/1ps
`default_nettype none

interface pixelWriteIf;
   import caPkg::*;

   logic    valid;                    // Writer has a pixel
   logic    ready;                    // Store takes it this edge
   xCoord_t x;
   yCoord_t y;
   logic    value;                    // Cell state, 1 is live

   modport writer (output valid, output x, output y, output value, input ready);
   modport store  (input valid, input x, input y, input value, output ready);
endinterface

`default_nettype wire

// ==== source/vgaScanIf.sv ====
// ----------------------------
// Scan position and raw timing flags
// ----------------------------
`timescale 1ns/1ps
`default_nettype none

interface vgaScanIf;
   import caPkg::*;

   xCoord_t x;                        // Current column
   yCoord_t y;                        // Current line
   logic    active;                   // Inside visible area
   logic    hSync;                    // High inside the sync pulse
   logic    vSync;
   logic    vBlank;                   // Lines below the visible area

   modport source (output x, output y, output active,
                   output hSync, output vSync, output vBlank);
   modport sink   (input x, input y, input active,
                   input hSync, input vSync, input vBlank);
endinterface

`default_nettype wire

// ==== source/vgaTiming.sv ====
// ----------------------------
// Horizontal and vertical scan counters
// Registered active, sync and vertical blank flags
// ----------------------------
`timescale 1ns/1ps
`default_nettype none
`include "caCfg.svh"

module vgaTiming (
   input  logic     VGA_CTRL_CLK,
   input  logic     reset,
   vgaScanIf.source scan
);
   import caPkg::*;

   localparam int hTotal     = `H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK;
   localparam int vTotal     = `V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK;
   localparam int hSyncStart = `H_ACTIVE + `H_FRONT;
   localparam int vSyncStart = `V_ACTIVE + `V_FRONT;

   xCoord_t    hCount;                // Pixel within line
   xCoord_t    hNext;
   logic [9:0] vCount;                // Line within frame, 525 needs 10 bits
   logic [9:0] vNext;

   // Counter wrap
   always_comb begin
      hNext = hCount + 1'b1;
      vNext = vCount;
      if (hCount == xCoord_t'(hTotal - 1)) begin
         hNext = '0;                                  // End of line
         if (vCount == 10'(vTotal - 1))
            vNext = '0;                               // End of frame
         else
            vNext = vCount + 1'b1;
      end
   end

   // ----------------------------
   // Counters and flags, decoded from next position
   // ----------------------------
   always_ff @(posedge VGA_CTRL_CLK) begin
      if (reset) begin
         hCount      <= '0;
         vCount      <= '0;
         scan.active <= 1'b1;                         // Position 0,0 is visible
         scan.hSync  <= 1'b0;
         scan.vSync  <= 1'b0;
         scan.vBlank <= 1'b0;
      end else begin
         hCount      <= hNext;
         vCount      <= vNext;
         scan.active <= (hNext < `H_ACTIVE) && (vNext < `V_ACTIVE);
         scan.hSync  <= (hNext >= hSyncStart) && (hNext < hSyncStart + `H_SYNC);
         scan.vSync  <= (vNext >= vSyncStart) && (vNext < vSyncStart + `V_SYNC);
         scan.vBlank <= (vNext >= `V_ACTIVE);         // Opens the write gate
      end
   end

   assign scan.x = hCount;
   assign scan.y = vCount[$bits(yCoord_t)-1:0];       // Aliases only in blanking

endmodule

`default_nettype wire

// ==== source/videoOut.sv ====
// ----------------------------
// Sync and blank alignment, white-on-black colour
// ----------------------------
`timescale 1ns/1ps
`default_nettype none

module videoOut (
   input  logic          VGA_CTRL_CLK,
   input  logic          reset,
   vgaScanIf.sink        scan,
   input  logic          pixelBit,
   output caPkg::color_t VGA_R,
   output caPkg::color_t VGA_G,
   output caPkg::color_t VGA_B,
   output logic          VGA_HS,
   output logic          VGA_VS,
   output logic          VGA_BLANK
);
   import caPkg::*;

   logic [1:0] hSyncDly;               // Two stages, matches memory plus output reg
   logic [1:0] vSyncDly;
   logic [1:0] activeDly;
   logic       pixelQ;                 // Memory bit, one stage
   color_t     pixelColor;

   always_ff @(posedge VGA_CTRL_CLK) begin
      if (reset) begin
         hSyncDly  <= '0;
         vSyncDly  <= '0;
         activeDly <= '0;
      end else begin
         hSyncDly  <= {hSyncDly[0], scan.hSync};
         vSyncDly  <= {vSyncDly[0], scan.vSync};
         activeDly <= {activeDly[0], scan.active};
      end
   end

   always_ff @(posedge VGA_CTRL_CLK) begin
      pixelQ <= pixelBit;
   end

   // Black outside active video, live cell is full white
   assign pixelColor = activeDly[1] ? {$bits(color_t){pixelQ}} : '0;

   assign VGA_R     = pixelColor;
   assign VGA_G     = pixelColor;
   assign VGA_B     = pixelColor;
   assign VGA_HS    = ~hSyncDly[1];     // Active low
   assign VGA_VS    = ~vSyncDly[1];
   assign VGA_BLANK = activeDly[1];     // High on visible pixels

endmodule

`default_nettype wire
